// ==== verilog/bp_settings.svh ====
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Branch predictor sizing.
////////////////////////////////////////////////////////////////////////////

// Number of entries in the direct mapped BTB.
// Must be a power of two.
`define BP_ENTRIES 64

// Width of a branch address in bits.
// Addresses are halfword aligned, so bit 0 is the offset.
`define BP_ADDR_WIDTH 32

`endif

// ==== verilog/bp_pkg.sv ====
`default_nettype none

`include "bp_settings.svh"

package bp_pkg;

        ////////////////////////////////////////////////////////////////////////////
        // Address breakup.
        ////////////////////////////////////////////////////////////////////////////

        // Index selects the entry, tag tells aliases apart.
        localparam int BP_INDEX_W = $clog2(`BP_ENTRIES);
        localparam int BP_TAG_W   = `BP_ADDR_WIDTH - BP_INDEX_W - 1;

        // Direct mapped split of a branch address.
        typedef struct packed {
                logic [BP_TAG_W-1:0]   tag;
                logic [BP_INDEX_W-1:0] index;
                logic                  offset;
        } t_bp_addr;

        // Two bit saturating branch state.
        typedef enum logic [1:0] {
                SNT = 2'd0,
                WNT = 2'd1,
                WT  = 2'd2,
                ST  = 2'd3
        } t_bp_state;

        // Payload of the target table RAM.
        typedef struct packed {
                logic [BP_TAG_W-1:0]       tag;
                logic [`BP_ADDR_WIDTH-1:0] target;
        } t_btb_entry;

        // New branch state from the reported one.
        // A mispredict moves toward the other side, a hit reinforces.
        function automatic t_bp_state bp_next_state(input t_bp_state cur, input logic nok);
                t_bp_state nxt;
                nxt = cur;
                if (nok)
                begin
                        case (cur)
                                SNT:     nxt = WNT;
                                WNT:     nxt = WT;
                                WT:      nxt = WNT;
                                default: nxt = WT;
                        endcase
                end
                else
                begin
                        case (cur)
                                SNT:     nxt = SNT;
                                WNT:     nxt = SNT;
                                WT:      nxt = ST;
                                default: nxt = ST;
                        endcase
                end
                return nxt;
        endfunction

endpackage

`default_nettype wire

// ==== verilog/bp_fb_if.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_settings.svh"

// Resolved branch feedback channel, valid/ready.
interface bp_fb_if
        import bp_pkg::*;
();

        logic                      valid;
        logic                      ready;
        // Address of the branch itself.
        t_bp_addr                  src;
        // Correct destination.
        logic [`BP_ADDR_WIDTH-1:0] dest;
        // State that was predicted for this branch.
        t_bp_state                 cur_state;
        // Set when the prediction was wrong.
        logic                      nok;

        // Producer side, from the top level inputs.
        modport source (output valid, output src, output dest, output cur_state,
                output nok, input ready);

        // Target table owns ready.
        modport btb (input valid, input src, input dest, output ready);

        // State table only needs the fire condition and state fields.
        modport state (input valid, input ready, input src, input cur_state, input nok);

endinterface

`default_nettype wire

// ==== verilog/bp_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_settings.svh"

// Simple dual port RAM.
// One write port, one read port, read data is registered.
module bp_ram #(
        parameter type T_DATA = logic [7:0],
        parameter int  DEPTH  = `BP_ENTRIES
) (
        input  logic                     i_clk,
        input  logic                     i_wr_en,
        input  logic [$clog2(DEPTH)-1:0] i_wr_addr,
        input  T_DATA                    i_wr_data,
        input  logic                     i_rd_en,
        input  logic [$clog2(DEPTH)-1:0] i_rd_addr,
        output T_DATA                    o_rd_data
);

        // Storage array.
        T_DATA mem [DEPTH];

        // Write port.
        always_ff @(posedge i_clk)
        begin
                if (i_wr_en)
                begin
                        mem[i_wr_addr] <= i_wr_data;
                end
        end

        // Read port.
        // Same edge write is not seen here, so a colliding read gets old data.
        always_ff @(posedge i_clk)
        begin
                if (i_rd_en)
                begin
                        o_rd_data <= mem[i_rd_addr];
                end
        end

        // Enabled read must have a known address.
        a_rd_addr_known: assert property (@(posedge i_clk)
                i_rd_en |-> !$isunknown(i_rd_addr));

endmodule

`default_nettype wire

// ==== verilog/btb_target_table.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_settings.svh"

// Target half of the BTB.
// Holds tag and target per entry, plus the valid bits.
module btb_target_table
        import bp_pkg::*;
(
        input  logic                i_clk,
        input  logic                i_reset,
        input  logic                i_stall,
        input  logic                i_clear,
        input  t_bp_addr            i_lookup,
        bp_fb_if.btb                fb,
        output t_btb_entry          o_entry,
        output logic                o_entry_valid,
        output logic [BP_TAG_W-1:0] o_lookup_tag
);

        logic                   fb_fire;
        t_btb_entry             wr_entry;
        logic [`BP_ENTRIES-1:0] valid_bits;

        ////////////////////////////////////////////////////////////////////////////
        // Feedback side.
        ////////////////////////////////////////////////////////////////////////////

        // Clear wins over a write, so hold feedback off while it is high.
        assign fb.ready = !i_clear;
        assign fb_fire  = fb.valid && fb.ready;

        // New entry from the resolved branch.
        assign wr_entry.tag    = fb.src.tag;
        assign wr_entry.target = fb.dest;

        // Tag and target storage.
        bp_ram #(
                .T_DATA (t_btb_entry),
                .DEPTH  (`BP_ENTRIES)
        ) u_entry_ram (
                .i_clk     (i_clk),
                .i_wr_en   (fb_fire),
                .i_wr_addr (fb.src.index),
                .i_wr_data (wr_entry),
                .i_rd_en   (!i_stall),
                .i_rd_addr (i_lookup.index),
                .o_rd_data (o_entry)
        );

        // Valid bits.
        // Clear drops all of them; a fired feedback marks its entry.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                begin
                        valid_bits <= '0;
                end
                else if (fb_fire)
                begin
                        valid_bits[fb.src.index] <= 1'b1;
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Lookup side, in step with the RAM read.
        ////////////////////////////////////////////////////////////////////////////

        // Valid bit of the entry being read.
        // Also dropped on clear, so an in-flight lookup cannot hit.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                begin
                        o_entry_valid <= 1'b0;
                end
                else if (!i_stall)
                begin
                        o_entry_valid <= valid_bits[i_lookup.index];
                end
        end

        // Tag of the lookup, compared against the read entry next stage.
        always_ff @(posedge i_clk)
        begin
                if (!i_stall)
                begin
                        o_lookup_tag <= i_lookup.tag;
                end
        end

        // A refused feedback stays pending with the same payload.
        a_fb_held: assert property (@(posedge i_clk) disable iff (i_reset)
                fb.valid && !fb.ready |=> fb.valid && $stable(fb.src) && $stable(fb.dest));

endmodule

`default_nettype wire

// ==== verilog/bp_state_table.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_settings.svh"

// State half of the BTB.
// One two bit saturating counter per entry.
module bp_state_table
        import bp_pkg::*;
(
        input  logic                  i_clk,
        input  logic                  i_stall,
        input  logic [BP_INDEX_W-1:0] i_lookup_index,
        bp_fb_if.state                fb,
        output t_bp_state             o_state
);

        logic      fb_fire;
        t_bp_state wr_state;

        ////////////////////////////////////////////////////////////////////////////
        // Update path.
        ////////////////////////////////////////////////////////////////////////////

        // Same fire condition as the target table.
        assign fb_fire = fb.valid && fb.ready;

        // Next state from the reported state and the outcome.
        assign wr_state = bp_next_state(fb.cur_state, fb.nok);

        ////////////////////////////////////////////////////////////////////////////
        // Storage.
        ////////////////////////////////////////////////////////////////////////////

        // Written at the source index, read at the lookup index.
        // Reads are frozen by a stall.
        bp_ram #(
                .T_DATA (t_bp_state),
                .DEPTH  (`BP_ENTRIES)
        ) u_state_ram (
                .i_clk     (i_clk),
                .i_wr_en   (fb_fire),
                .i_wr_addr (fb.src.index),
                .i_wr_data (wr_state),
                .i_rd_en   (!i_stall),
                .i_rd_addr (i_lookup_index),
                .o_rd_data (o_state)
        );

endmodule

`default_nettype wire

// ==== verilog/bp_redirect.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_settings.svh"

// Redirect decision.
// Second stage of the lookup, registers what fetch sees.
module bp_redirect
        import bp_pkg::*;
(
        input  logic                      i_clk,
        input  logic                      i_reset,
        input  logic                      i_stall,
        input  t_btb_entry                i_entry,
        input  logic                      i_entry_valid,
        input  logic [BP_TAG_W-1:0]       i_lookup_tag,
        input  t_bp_state                 i_state,
        output logic                      o_redirect,
        output logic [`BP_ADDR_WIDTH-1:0] o_redirect_pc,
        output t_bp_state                 o_branch_state
);

        logic tag_hit;
        logic taken;

        // Entry belongs to this branch.
        assign tag_hit = i_entry_valid && (i_entry.tag == i_lookup_tag);

        // Upper half of the counter predicts taken.
        assign taken = (i_state == WT) || (i_state == ST);

        // Output stage, held on a stall.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_redirect     <= 1'b0;
                        o_redirect_pc  <= '0;
                        o_branch_state <= SNT;
                end
                else if (!i_stall)
                begin
                        // State goes out on every lookup.
                        o_branch_state <= i_state;
                        if (tag_hit && taken)
                        begin
                                // Restart fetch at the stored target.
                                o_redirect    <= 1'b1;
                                o_redirect_pc <= i_entry.target;
                        end
                        else
                        begin
                                o_redirect <= 1'b0;
                        end
                end
        end

        // Targets come from halfword aligned feedback.
        a_redirect_pc_even: assert property (@(posedge i_clk) disable iff (i_reset)
                o_redirect |-> (o_redirect_pc[0] == 1'b0));

endmodule

`default_nettype wire

// ==== verilog/bp_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_settings.svh"

// Branch predictor for the fetch stage.
module bp_top
        import bp_pkg::*;
(
        input  logic                      i_clk,
        input  logic                      i_reset,
        input  logic                      i_stall,
        input  logic                      i_clear,
        input  t_bp_addr                  i_lookup_addr,
        input  logic                      i_fb_valid,
        output logic                      o_fb_ready,
        input  t_bp_addr                  i_fb_src,
        input  logic [`BP_ADDR_WIDTH-1:0] i_fb_dest,
        input  t_bp_state                 i_fb_state,
        input  logic                      i_fb_nok,
        output logic                      o_redirect,
        output logic [`BP_ADDR_WIDTH-1:0] o_redirect_pc,
        output t_bp_state                 o_branch_state
);

        // Read stage results.
        t_btb_entry          entry;
        logic                entry_valid;
        logic [BP_TAG_W-1:0] lookup_tag;
        t_bp_state           rd_state;

        ////////////////////////////////////////////////////////////////////////////
        // Feedback channel, sourced from the top level pins.
        ////////////////////////////////////////////////////////////////////////////

        bp_fb_if fb ();

        assign fb.valid     = i_fb_valid;
        assign fb.src       = i_fb_src;
        assign fb.dest      = i_fb_dest;
        assign fb.cur_state = i_fb_state;
        assign fb.nok       = i_fb_nok;
        assign o_fb_ready   = fb.ready;

        // Tag, target and valid bits.
        btb_target_table u_target_table (
                .i_clk         (i_clk),
                .i_reset       (i_reset),
                .i_stall       (i_stall),
                .i_clear       (i_clear),
                .i_lookup      (i_lookup_addr),
                .fb            (fb.btb),
                .o_entry       (entry),
                .o_entry_valid (entry_valid),
                .o_lookup_tag  (lookup_tag)
        );

        // Branch state counters, same index.
        bp_state_table u_state_table (
                .i_clk          (i_clk),
                .i_stall        (i_stall),
                .i_lookup_index (i_lookup_addr.index),
                .fb             (fb.state),
                .o_state        (rd_state)
        );

        // Hit check and output registers.
        bp_redirect u_redirect (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_stall        (i_stall),
                .i_entry        (entry),
                .i_entry_valid  (entry_valid),
                .i_lookup_tag   (lookup_tag),
                .i_state        (rd_state),
                .o_redirect     (o_redirect),
                .o_redirect_pc  (o_redirect_pc),
                .o_branch_state (o_branch_state)
        );

endmodule

`default_nettype wire

// ==== dv/bp_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_settings.svh"

// Watches the DUT ports.
// Mirrors both tables and the two lookup stages, then compares the outputs.
module bp_checker
        import bp_pkg::*;
(
        input  logic                      i_clk,
        input  logic                      i_reset,
        input  logic                      i_stall,
        input  logic                      i_clear,
        input  logic                      i_fb_valid,
        input  logic                      i_fb_ready,
        input  logic                      i_fb_nok,
        input  logic                      i_redirect,
        input  t_bp_addr                  i_lookup_addr,
        input  t_bp_addr                  i_fb_src,
        input  logic [`BP_ADDR_WIDTH-1:0] i_fb_dest,
        input  logic [`BP_ADDR_WIDTH-1:0] i_redirect_pc,
        input  t_bp_state                 i_fb_state,
        input  t_bp_state                 i_branch_state
);

        int errors = 0;
        int checks = 0;

        // Copy of the tables, one slot per index.
        // State storage has no reset, so track which slots hold a known state.
        t_btb_entry entries [`BP_ENTRIES];
        t_bp_state  states [`BP_ENTRIES];
        logic       written [`BP_ENTRIES] = '{default: 1'b0};
        logic       valids [`BP_ENTRIES];

        // Read stage, one advancing edge after the lookup.
        t_btb_entry          rd_entry;
        t_bp_state           rd_state;
        logic                rd_written = 1'b0;
        logic                rd_valid;
        logic [BP_TAG_W-1:0] rd_tag;

        // Output stage, two advancing edges after the lookup.
        logic                      exp_redirect;
        logic [`BP_ADDR_WIDTH-1:0] exp_pc;
        t_bp_state                 exp_state;
        logic                      exp_known = 1'b0;

        // Counts one check, reports a mismatch right away.
        task automatic compare_value(input string name, input logic [31:0] expected,
                input logic [31:0] actual);
                checks++;
                if (actual !== expected)
                begin
                        errors++;
                        $display("[ERROR] %s: expected %h, actual %h at %0t ns",
                                name, expected, actual, $time);
                end
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Model, stepped on every rising edge.
        ////////////////////////////////////////////////////////////////////////////

        always @(posedge i_clk)
        begin
                // Output stage takes the read stage from before this edge.
                if (i_reset)
                begin
                        exp_redirect = 1'b0;
                        exp_pc       = '0;
                        exp_state    = SNT;
                        exp_known    = 1'b1;
                end
                else if (!i_stall)
                begin
                        exp_state    = rd_state;
                        exp_known    = rd_written;
                        // Hit on a valid entry with a taken state (WT or ST).
                        exp_redirect = rd_valid && (rd_entry.tag == rd_tag)
                                && (rd_state == WT || rd_state == ST);
                        // The target only moves on a redirect.
                        if (exp_redirect)
                                exp_pc = rd_entry.target;
                end

                // Read stage sees the tables before this edge's write.
                // A clear drops the in-flight valid even on a stalled edge.
                if (i_reset || i_clear)
                        rd_valid = 1'b0;
                else if (!i_stall)
                        rd_valid = valids[i_lookup_addr.index];
                if (!i_stall)
                begin
                        rd_entry   = entries[i_lookup_addr.index];
                        rd_state   = states[i_lookup_addr.index];
                        rd_written = written[i_lookup_addr.index];
                        rd_tag     = i_lookup_addr.tag;
                end

                // Feedback lands only while clear is low.
                if (i_reset || i_clear)
                        valids = '{default: 1'b0};
                else if (i_fb_valid)
                        valids[i_fb_src.index] = 1'b1;
                if (i_fb_valid && !i_clear)
                begin
                        entries[i_fb_src.index].tag    = i_fb_src.tag;
                        entries[i_fb_src.index].target = i_fb_dest;
                        states[i_fb_src.index]         = bp_next_state(i_fb_state, i_fb_nok);
                        written[i_fb_src.index]        = 1'b1;
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Compare on the falling edge, where the DUT outputs are settled.
        ////////////////////////////////////////////////////////////////////////////

        always @(negedge i_clk)
        begin
                if (!i_reset)
                begin
                        // Ready is low exactly while clear is high.
                        compare_value("fb_ready", 32'(!i_clear), 32'(i_fb_ready));
                        compare_value("redirect", 32'(exp_redirect), 32'(i_redirect));
                        compare_value("redirect_pc", exp_pc, i_redirect_pc);
                        // A slot never written has no defined state yet
                        if (exp_known)
                                compare_value("branch_state", 32'(exp_state),
                                        32'(i_branch_state));
                end
        end

endmodule

`default_nettype wire

// ==== dv/bp_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_settings.svh"

// Random stimulus for the branch predictor.
// Comparing is done in bp_checker.
module bp_tb
        import bp_pkg::*;
();

        localparam int RESET_CYCLES = 5;
        localparam int RUN_CYCLES   = 3000;
        localparam int DRAIN_CYCLES = 4;
        // Stimulus length plus a third as margin.
        localparam int MAX_CYCLES   = RUN_CYCLES * 4 / 3;

        logic                      i_clk = 1'b0;
        logic                      i_reset;
        logic                      i_stall;
        logic                      i_clear;
        logic                      i_fb_valid;
        logic                      i_fb_nok;
        logic                      o_fb_ready;
        logic                      o_redirect;
        t_bp_addr                  i_lookup_addr;
        t_bp_addr                  i_fb_src;
        logic [`BP_ADDR_WIDTH-1:0] i_fb_dest;
        logic [`BP_ADDR_WIDTH-1:0] o_redirect_pc;
        t_bp_state                 i_fb_state;
        t_bp_state                 o_branch_state;
        int                        cycles = 0;

        bp_top uut (.*);

        bp_checker u_checker (
                .*,
                .i_fb_ready     (o_fb_ready),
                .i_redirect     (o_redirect),
                .i_redirect_pc  (o_redirect_pc),
                .i_branch_state (o_branch_state)
        );

        // 20 ns period.
        always #10 i_clk = ~i_clk;

        // Cycle count for the timeout.
        always @(posedge i_clk)
                cycles <= cycles + 1;

        // Four tags over eight indices.
        // Hits and aliases then come often.
        function automatic t_bp_addr pick_addr();
                t_bp_addr a;
                a = t_bp_addr'($urandom());
                a.tag[BP_TAG_W-1:2]     = '0;
                a.index[BP_INDEX_W-1:3] = '0;
                return a;
        endfunction

        // New inputs for one cycle.
        // A feedback refused during a clear is held until it is taken.
        task automatic drive_inputs();
                logic hold;
                hold          = i_fb_valid && i_clear;
                i_stall       = ($urandom_range(99) < 20);
                i_clear       = ($urandom_range(99) < 2);
                i_lookup_addr = pick_addr();
                if (!hold)
                begin
                        i_fb_valid = ($urandom_range(99) < 40);
                        i_fb_src   = pick_addr();
                        // Targets are halfword aligned.
                        i_fb_dest  = $urandom() & 32'hffff_fffe;
                        i_fb_state = t_bp_state'(2'($urandom_range(3)));
                        i_fb_nok   = 1'($urandom_range(1));
                end
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Run control.
        ////////////////////////////////////////////////////////////////////////////

        initial
        begin
                wait (cycles >= MAX_CYCLES);
                $display("Timeout, the run did not finish within %0d cycles.", MAX_CYCLES);
                $display("CHECKS FAILED");
                $finish;
        end

        initial
        begin
                void'($urandom(32'h82db_bca1));
                i_reset       = 1'b1;
                i_stall       = 1'b0;
                i_clear       = 1'b0;
                i_lookup_addr = '0;
                i_fb_valid    = 1'b0;
                i_fb_src      = '0;
                i_fb_dest     = '0;
                i_fb_state    = SNT;
                i_fb_nok      = 1'b0;
                repeat (RESET_CYCLES) @(posedge i_clk);
                #1;
                i_reset = 1'b0;

                // Inputs change 1 ns after each rising edge.
                repeat (RUN_CYCLES)
                begin
                        drive_inputs();
                        @(posedge i_clk);
                        #1;
                end

                // Let a held feedback land, then flush the two lookup stages.
                i_stall = 1'b0;
                i_clear = 1'b0;
                @(posedge i_clk);
                #1;
                i_fb_valid = 1'b0;
                repeat (DRAIN_CYCLES) @(posedge i_clk);
                @(negedge i_clk);

                $display("Summary: %0d checks, %0d errors", u_checker.checks,
                        u_checker.errors);
                if (u_checker.errors == 0)
                        $display("ALL CHECKS PASSED");
                else
                        $display("CHECKS FAILED");
                $finish;
        end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verilog
verilog/bp_pkg.sv
verilog/bp_fb_if.sv
verilog/bp_ram.sv
verilog/btb_target_table.sv
verilog/bp_state_table.sv
verilog/bp_redirect.sv
verilog/bp_top.sv
dv/bp_checker.sv
dv/bp_tb.sv

// ==== Makefile ====
# Verilator simulation of the branch predictor.
# Any variable can be overridden on the command line, e.g. make sim LOG=run.log

TOP    ?= bp_tb
LOG    ?= sim.log
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Build, run, then decide pass or fail from the log.
sim:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f project.f
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || echo "CHECKS FAILED" >> $(LOG)
	cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed."; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
